// File: source/icache_geom_pkg.sv
package icache_geom_pkg;

	//////////////////////////////
	// Geometry
	//////////////////////////////

	localparam int n_ways         = 4;                            // Associativity
	localparam int n_sets         = 64;
	localparam int tag_bits       = 22;
	localparam int index_bits     = $clog2(n_sets);               // 6 index bits for 64 sets
	localparam int words_per_line = 4;
	localparam int word_bits      = $clog2(words_per_line);
	localparam int byte_bits      = 2;                            // Byte offset inside a word
	localparam int inst_bits      = 32;
	localparam int line_bits      = words_per_line * inst_bits;   // 128 bit line
	localparam int addr_bits      = tag_bits + index_bits + word_bits + byte_bits;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [n_ways-1:0] way_t;                             // One-hot way vector
	typedef logic [line_bits-1:0] line_t;

	typedef struct packed {
		logic [tag_bits-1:0]   tag;
		logic [index_bits-1:0] index;
		logic [word_bits-1:0]  word;                              // Word inside the line
		logic [byte_bits-1:0]  byte_idx;
	} icache_addr_f_t;

	// A fetch address seen either as one word or split into its fields
	typedef union packed {
		logic [addr_bits-1:0] raw;
		icache_addr_f_t       f;
	} icache_addr_u;

endpackage

// File: source/icache_msg_pkg.sv
package icache_msg_pkg;

	//////////////////////////////
	// Fetch side
	//////////////////////////////

	typedef struct packed {
		logic                         valid;
		icache_geom_pkg::icache_addr_u addr;                      // Byte address of the instruction
	} fetch_req_t;

	//////////////////////////////
	// Inside the cache
	//////////////////////////////

	// Write of one line into one way of both stores
	typedef struct packed {
		logic                  en;
		icache_geom_pkg::way_t way;                               // One-hot victim way
		icache_geom_pkg::line_t line;                             // Line straight from memory
	} fill_t;

	// Output stage register, one cycle behind the lookup
	typedef struct packed {
		logic                                     valid;
		icache_geom_pkg::way_t                    hit;            // Zero means the fill line is used
		logic [icache_geom_pkg::word_bits-1:0]    word;
		icache_geom_pkg::line_t                   line;           // Captured fill line
	} stage_t;

endpackage

// File: source/icache_ctrl.sv
module icache_ctrl (
	input  logic                                  clk,
	input  logic                                  rst,
	input  icache_msg_pkg::fetch_req_t            fetch,
	input  logic                                  stall,
	input  logic                                  flush,
	input  icache_geom_pkg::way_t                 hit,
	input  icache_geom_pkg::line_t                mem_line,
	output icache_geom_pkg::icache_addr_u         lookup,
	output icache_msg_pkg::fill_t                 fill,
	output icache_msg_pkg::stage_t                stage,
	output logic                                  mem_req,
	output logic [icache_geom_pkg::addr_bits-1:0] mem_addr
);
	import icache_geom_pkg::*;

	icache_addr_u held_q;                                         // Address of the fetch in the stage
	way_t         victim_q;                                       // Rotating one-hot victim
	logic         valid_q;
	way_t         hit_q;
	line_t        line_q;
	logic         miss;

	//////////////////////////////
	// Lookup and fill decision
	//////////////////////////////

	// A stalled stage replays its own address so the data store re-reads the same set
	assign lookup = stall ? held_q : fetch.addr;
	assign miss   = (hit == '0);

	always_comb begin
		fill.en   = fetch.valid && miss && !stall;                // Memory answers in the same cycle
		fill.way  = victim_q;
		fill.line = mem_line;
	end

	assign mem_req  = fill.en;
	assign mem_addr = {lookup.f.tag, lookup.f.index, {(word_bits + byte_bits){1'b0}}};

	//////////////////////////////
	// Output stage
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q  <= 1'b0;
			hit_q    <= '0;
			victim_q <= way_t'(1);                                // Start at way 0
		end else if (!stall) begin
			if (flush) begin
				valid_q <= 1'b0;                                  // Drop the word in flight
				hit_q   <= '0;
			end else begin
				valid_q  <= fetch.valid;
				hit_q    <= hit;
				victim_q <= {victim_q[n_ways-2:0], victim_q[n_ways-1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			held_q <= fetch.addr;
			line_q <= mem_line;                                   // Used when the fetch missed
		end
	end

	always_comb begin
		stage.valid = valid_q;
		stage.hit   = hit_q;
		stage.word  = held_q.f.word;
		stage.line  = line_q;
	end

	a_victim_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(victim_q))
		else $error("icache_ctrl: victim pointer lost its one-hot form");

endmodule

// File: source/icache_tag_store.sv
module icache_tag_store (
	input  logic                          clk,
	input  logic                          rst,
	input  icache_geom_pkg::icache_addr_u lookup,
	input  icache_msg_pkg::fill_t         fill,
	output icache_geom_pkg::way_t         hit
);
	import icache_geom_pkg::*;

	logic [tag_bits-1:0]             tag_mem [n_ways][n_sets];
	logic [n_ways-1:0][n_sets-1:0]   valid_q;                     // One valid vector per way

	//////////////////////////////
	// Fill write
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (fill.en) begin
			for (int w = 0; w < n_ways; w++) begin
				if (fill.way[w]) begin
					valid_q[w][lookup.f.index] <= 1'b1;
				end
			end
		end
	end

	// Fills always happen on the current lookup address
	always_ff @(posedge clk) begin
		if (fill.en) begin
			for (int w = 0; w < n_ways; w++) begin
				if (fill.way[w]) begin
					tag_mem[w][lookup.f.index] <= lookup.f.tag;
				end
			end
		end
	end

	//////////////////////////////
	// Compare
	//////////////////////////////

	always_comb begin
		for (int w = 0; w < n_ways; w++) begin
			hit[w] = valid_q[w][lookup.f.index] && (tag_mem[w][lookup.f.index] == lookup.f.tag);
		end
	end

	// Holds only while a fill never lands on a tag already present in the set
	a_hit_onehot0: assert property (@(posedge clk) disable iff (rst) $onehot0(hit))
		else $error("icache_tag_store: tag present in more than one way");

endmodule

// File: source/icache_data_store.sv
module icache_data_store (
	input  logic                                         clk,
	input  icache_geom_pkg::icache_addr_u                lookup,
	input  icache_msg_pkg::fill_t                        fill,
	output icache_geom_pkg::line_t [icache_geom_pkg::n_ways-1:0] rd_lines
);
	import icache_geom_pkg::*;

	line_t line_mem [n_ways][n_sets];                             // Inferred line arrays, one per way

	//////////////////////////////
	// Read and fill
	//////////////////////////////

	// The read returns the old line when it collides with a fill at the same edge
	always_ff @(posedge clk) begin
		for (int w = 0; w < n_ways; w++) begin
			if (fill.en && fill.way[w]) begin
				line_mem[w][lookup.f.index] <= fill.line;
			end
			rd_lines[w] <= line_mem[w][lookup.f.index];           // Presented one cycle later
		end
	end

endmodule

// File: source/icache_out_sel.sv
module icache_out_sel (
	input  icache_msg_pkg::stage_t                               stage,
	input  icache_geom_pkg::line_t [icache_geom_pkg::n_ways-1:0] rd_lines,
	output logic [icache_geom_pkg::inst_bits-1:0]                inst,
	output logic                                                 inst_valid
);
	import icache_geom_pkg::*;

	line_t sel_line;

	//////////////////////////////
	// Way and word select
	//////////////////////////////

	always_comb begin
		sel_line = stage.line;                                    // Miss takes the captured fill line
		for (int w = 0; w < n_ways; w++) begin
			if (stage.hit[w]) begin
				sel_line = rd_lines[w];
			end
		end
	end

	assign inst       = sel_line[stage.word * inst_bits +: inst_bits];
	assign inst_valid = stage.valid;

	// A valid stage must name at most one way
	always_comb begin
		if (stage.valid === 1'b1) begin
			a_stage_hit_onehot0: assert ($onehot0(stage.hit))
				else $error("icache_out_sel: stage names more than one hit way");
		end
	end

endmodule

// File: source/icache_top.sv
module icache_top (
	input  logic                                  clk,
	input  logic                                  rst,
	input  icache_msg_pkg::fetch_req_t            fetch,
	input  logic                                  stall,
	input  logic                                  flush,
	input  icache_geom_pkg::line_t                mem_line,
	output logic                                  mem_req,
	output logic [icache_geom_pkg::addr_bits-1:0] mem_addr,
	output logic [icache_geom_pkg::inst_bits-1:0] inst,
	output logic                                  inst_valid
);
	import icache_geom_pkg::*;
	import icache_msg_pkg::*;

	icache_addr_u            lookup;                              // Address used for this cycle's lookup
	way_t                    hit;
	fill_t                   fill;
	stage_t                  stage;
	line_t [n_ways-1:0]      rd_lines;                            // Registered reads of all ways

	icache_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.fetch    (fetch),
		.stall    (stall),
		.flush    (flush),
		.hit      (hit),
		.mem_line (mem_line),
		.lookup   (lookup),
		.fill     (fill),
		.stage    (stage),
		.mem_req  (mem_req),
		.mem_addr (mem_addr)
	);

	icache_tag_store u_tag_store (
		.clk    (clk),
		.rst    (rst),
		.lookup (lookup),
		.fill   (fill),
		.hit    (hit)
	);

	icache_data_store u_data_store (
		.clk      (clk),
		.lookup   (lookup),
		.fill     (fill),
		.rd_lines (rd_lines)
	);

	icache_out_sel u_out_sel (
		.stage      (stage),
		.rd_lines   (rd_lines),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

endmodule

// File: bench/icache_tb.sv
module icache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import icache_geom_pkg::*;
	import icache_msg_pkg::*;

	localparam int clk_period    = 8;
	localparam int reset_cycles  = 16;
	localparam int idle_cycles   = 4;
	localparam int evict_cycles  = 10;
	localparam int hold_cycles   = 6;
	localparam int random_cycles = 2000 - idle_cycles - evict_cycles - hold_cycles;
	localparam int total_cycles  = reset_cycles + idle_cycles + evict_cycles + hold_cycles
		+ random_cycles;

	logic                 clk = 1'b0;
	logic                 rst;
	fetch_req_t           fetch;
	logic                 stall;
	logic                 flush;
	line_t                mem_line;
	logic                 mem_req;
	logic [31:0]          mem_addr;
	logic [31:0]          inst;
	logic                 inst_valid;
	integer               seed = 32'hc98e549b;

	logic [tag_bits-1:0]  m_tag [n_ways][n_sets];                 // Reference tags
	logic                 m_valid [n_ways][n_sets];
	int                   m_victim;                               // Way number of the next fill
	logic                 exp_valid;
	logic [31:0]          exp_inst;
	logic [31:0]          last_inst;
	logic                 last_stall;
	logic                 last_req;                               // Mem_req seen in the last step

	icache_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.fetch      (fetch),
		.stall      (stall),
		.flush      (flush),
		.mem_line   (mem_line),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.inst       (inst),
		.inst_valid (inst_valid)
	);

	always #(clk_period / 2) clk = ~clk;

	//////////////////////////////
	// Memory model
	//////////////////////////////

	function automatic logic [31:0] mem_word(input logic [31:0] line_addr, input logic [1:0] w);
		logic [31:0] k;
		k = {30'd0, w} + 32'd1;
		return (line_addr * 32'h9e3779b1) ^ (k * 32'h85ebca6b) ^ (line_addr >> 9);
	endfunction

	always_comb begin
		for (int w = 0; w < words_per_line; w++) begin
			mem_line[w*inst_bits +: inst_bits] = mem_word(mem_addr, w[1:0]);   // Word 0 sits low
		end
	end

	function automatic logic [31:0] make_addr(input logic [tag_bits-1:0] tag,
		input logic [index_bits-1:0] index, input logic [1:0] word);
		return {tag, index, word, 2'b00};
	endfunction

	task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "run stopped at the first error");
		end
	endtask

	//////////////////////////////
	// One cycle with the model
	//////////////////////////////

	task automatic step(input logic v, input logic [31:0] a, input logic s, input logic f);
		icache_addr_u addr;
		logic         hit_any;
		logic         miss;
		addr.raw = a;
		@(negedge clk);
		fetch.valid = v;
		fetch.addr  = addr;
		stall       = s;
		flush       = f;
		#2;                                                       // Let the lookup settle
		hit_any = 1'b0;
		for (int w = 0; w < n_ways; w++) begin
			if (m_valid[w][addr.f.index] && m_tag[w][addr.f.index] == addr.f.tag) begin
				hit_any = 1'b1;
			end
		end
		miss = v && !hit_any && !s;
		check("mem_req", {31'd0, miss}, {31'd0, mem_req});
		if (miss) begin
			check("mem_addr", {a[31:4], 4'd0}, mem_addr);
		end
		check("inst_valid", {31'd0, exp_valid}, {31'd0, inst_valid});
		if (exp_valid) begin
			check("inst", exp_inst, inst);
		end
		if (last_stall) begin
			check("stall_hold", last_inst, inst);                 // Stage froze at the last edge
		end
		last_inst  = inst;
		last_stall = s;
		last_req   = mem_req;
		@(posedge clk);
		if (miss) begin
			m_tag[m_victim][addr.f.index]   = addr.f.tag;
			m_valid[m_victim][addr.f.index] = 1'b1;
		end
		if (!s) begin
			if (f) begin
				exp_valid = 1'b0;
			end else begin
				exp_valid = v;
				exp_inst  = mem_word({a[31:4], 4'd0}, a[3:2]);
				m_victim  = (m_victim + 1) % n_ways;
			end
		end
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		logic [tag_bits-1:0] evicted;
		logic [31:0]         r;
		fetch = '0;
		stall = 1'b0;
		flush = 1'b0;
		rst   = 1'b1;
		for (int w = 0; w < n_ways; w++) begin
			for (int i = 0; i < n_sets; i++) begin
				m_valid[w][i] = 1'b0;
			end
		end
		m_victim   = 0;
		exp_valid  = 1'b0;
		exp_inst   = '0;
		last_inst  = '0;
		last_stall = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		repeat (idle_cycles) step(1'b0, 32'd0, 1'b0, 1'b0);     // Outputs stay quiet before a fetch

		// Four tags fill one set, then a fifth pushes out the victim's tag
		for (int i = 0; i < 4; i++) begin
			step(1'b1, make_addr(22'h100 + 22'(i), 6'd5, i[1:0]), 1'b0, 1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			step(1'b1, make_addr(22'h100 + 22'(i), 6'd5, 2'd3), 1'b0, 1'b0);
			check("evict_rehit", 32'd0, {31'd0, last_req});
		end
		evicted = m_tag[m_victim][5];
		step(1'b1, make_addr(22'h104, 6'd5, 2'd0), 1'b0, 1'b0);
		step(1'b1, make_addr(evicted, 6'd5, 2'd1), 1'b0, 1'b0);
		check("evict_refetch", 32'd1, {31'd0, last_req});

		step(1'b1, make_addr(22'h2f1, 6'd9, 2'd2), 1'b0, 1'b0);
		repeat (3) step(1'b1, make_addr(22'h2f2, 6'd9, 2'd0), 1'b1, 1'b0);
		step(1'b1, make_addr(22'h2f3, 6'd9, 2'd1), 1'b0, 1'b1);  // Flush drops this word
		step(1'b0, 32'd0, 1'b0, 1'b0);

		for (int n = 0; n < random_cycles; n++) begin
			r = $random(seed);
			step(r[9:8] != 2'd0,
				make_addr(22'h2c0 + {19'd0, r[2:0]}, 6'd12 + {4'd0, r[4:3]}, r[6:5]),
				r[12:10] == 3'd0, r[16:13] == 4'd0);
		end
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(total_cycles * clk_period + 200);
		$display("watchdog timeout, the tests did not finish in time");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: build.f
source/icache_geom_pkg.sv
source/icache_msg_pkg.sv
source/icache_ctrl.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/icache_out_sel.sv
source/icache_top.sv
bench/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= icache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
